//--- verilog/nes_bus_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES CPU bus constants
// Register addresses and memory sizes for the bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef NES_BUS_PARAMS_SVH
`define NES_BUS_PARAMS_SVH

// PPU sprite registers
`define NES_ADDR_OAMADDR    16'h2003
`define NES_ADDR_OAMDATA    16'h2004

// Writing a page number here starts the sprite DMA
`define NES_ADDR_OAMDMA     16'h4014

// 2 KB work RAM, repeated four times up to $1FFF
`define NES_RAM_ADDR_BITS   11
`define NES_RAM_MIRROR_END  16'h1fff

`define NES_OAM_SIZE        256

`endif

//--- verilog/nes_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES bus types
// Bus cycle struct, decoded target and DMA states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package nes_bus_pkg;

    // One cycle on the 6502 bus
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rw;        // 1 = read
    } bus_req_t;

    // Target of a decoded cycle
    typedef enum logic [2:0] {
        SEL_RAM,
        SEL_OAMADDR,
        SEL_OAMDATA,
        SEL_DMA_REG,
        SEL_NONE
    } slave_sel_e;

    // Sprite DMA sequencer states
    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_START,
        DMA_READ,
        DMA_WRITE
    } dma_state_e;

endpackage

//--- verilog/oam_dma.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OAM DMA engine
// Copies one 256-byte page to $2004, read then write
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "nes_bus_params.svh"

module oam_dma import nes_bus_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_clk_en,
    input  logic       i_start,
    input  logic [7:0] i_page,
    input  logic [7:0] i_rdata,
    output bus_req_t   o_req,
    output logic       o_active
);

    dma_state_e  r_state;
    logic [15:0] r_src_addr;
    logic [7:0]  r_count;
    logic [7:0]  r_data;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            r_state <= DMA_IDLE;
        end else if (i_clk_en) begin
            case (r_state)
                DMA_IDLE: begin
                    if (i_start) begin
                        r_state <= DMA_START;
                    end
                end
                DMA_START: begin
                    r_state <= DMA_READ;
                end
                DMA_READ: begin
                    r_state <= DMA_WRITE;
                end
                DMA_WRITE: begin
                    // Last byte done when the counter has run down
                    if (r_count == 8'd0) begin
                        r_state <= DMA_IDLE;
                    end else begin
                        r_state <= DMA_READ;
                    end
                end
                default: begin
                    r_state <= DMA_IDLE;
                end
            endcase
        end
    end

    // Source address, byte counter and the byte in flight
    always_ff @(posedge i_clk) begin
        if (i_clk_en) begin
            case (r_state)
                DMA_IDLE: begin
                    if (i_start) begin
                        r_src_addr <= {i_page, 8'h00};
                    end
                end
                DMA_START: begin
                    r_count <= 8'hff;
                end
                DMA_READ: begin
                    r_data <= i_rdata;
                end
                DMA_WRITE: begin
                    r_count    <= r_count - 8'd1;
                    r_src_addr <= r_src_addr + 16'd1;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        o_req.addr  = 16'h0000;
        o_req.wdata = 8'h00;
        o_req.rw    = 1'b1;
        case (r_state)
            DMA_READ: begin
                o_req.addr = r_src_addr;
            end
            DMA_WRITE: begin
                o_req.addr  = `NES_ADDR_OAMDATA;
                o_req.wdata = r_data;
                o_req.rw    = 1'b0;
            end
            // Idle and the dummy start cycle read $0000
            default: begin
            end
        endcase
    end

    assign o_active = (r_state != DMA_IDLE);

    // A new trigger cannot come from the CPU while it is frozen
    a_no_start_when_active: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_clk_en && o_active |-> !i_start
    );

endmodule

//--- verilog/bus_controller.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus controller
// Master mux, address decode, read return, open bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "nes_bus_params.svh"

module bus_controller import nes_bus_pkg::*; (
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic                          i_clk_en,
    input  bus_req_t                      i_cpu_req,
    input  bus_req_t                      i_dma_req,
    input  logic                          i_dma_active,
    input  logic [7:0]                    i_ram_rdata,
    input  logic [7:0]                    i_oam_rdata,
    output logic                          o_ram_we,
    output logic [`NES_RAM_ADDR_BITS-1:0] o_ram_index,
    output logic                          o_oam_addr_we,
    output logic                          o_oam_data_we,
    output logic                          o_oam_data_re,
    output logic [7:0]                    o_wdata,
    output logic                          o_dma_start,
    output logic [7:0]                    o_dma_page,
    output logic [7:0]                    o_cpu_rdata,
    output logic                          o_cpu_clk_en
);

    bus_req_t   w_req;
    slave_sel_e w_sel;
    logic       w_cycle_en;
    logic       w_wr;
    logic [7:0] r_open_bus;
    logic       r_cpu_ready;

    // CPU stays frozen until the first edge out of reset
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            r_cpu_ready <= 1'b0;
        end else begin
            r_cpu_ready <= 1'b1;
        end
    end

    assign o_cpu_clk_en = i_clk_en & r_cpu_ready & ~i_dma_active;

    // DMA owns the bus while it runs
    assign w_req      = i_dma_active ? i_dma_req : i_cpu_req;
    assign w_cycle_en = i_clk_en & (i_dma_active | r_cpu_ready);
    assign w_wr       = ~w_req.rw;

    always_comb begin
        if (w_req.addr <= `NES_RAM_MIRROR_END) begin
            w_sel = SEL_RAM;
        end else if (w_req.addr == `NES_ADDR_OAMADDR) begin
            w_sel = SEL_OAMADDR;
        end else if (w_req.addr == `NES_ADDR_OAMDATA) begin
            w_sel = SEL_OAMDATA;
        end else if (w_req.addr == `NES_ADDR_OAMDMA) begin
            w_sel = SEL_DMA_REG;
        end else begin
            w_sel = SEL_NONE;
        end
    end

    // Low 11 bits fold the four RAM mirrors together
    assign o_ram_index   = w_req.addr[`NES_RAM_ADDR_BITS-1:0];
    assign o_wdata       = w_req.wdata;
    assign o_ram_we      = w_cycle_en & w_wr & (w_sel == SEL_RAM);
    assign o_oam_addr_we = w_cycle_en & w_wr & (w_sel == SEL_OAMADDR);
    assign o_oam_data_we = w_cycle_en & w_wr & (w_sel == SEL_OAMDATA);
    assign o_oam_data_re = w_cycle_en & w_req.rw & (w_sel == SEL_OAMDATA);
    assign o_dma_start   = w_cycle_en & w_wr & (w_sel == SEL_DMA_REG);
    assign o_dma_page    = w_req.wdata;

    // Write-only and unmapped registers read back the open bus
    always_comb begin
        case (w_sel)
            SEL_RAM:     o_cpu_rdata = i_ram_rdata;
            SEL_OAMDATA: o_cpu_rdata = i_oam_rdata;
            default:     o_cpu_rdata = r_open_bus;
        endcase
    end

    // Data bus capacitance holds whatever was last driven
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            r_open_bus <= 8'h00;
        end else if (w_cycle_en) begin
            r_open_bus <= w_req.rw ? o_cpu_rdata : w_req.wdata;
        end
    end

    // DMA cycles never address $4014 for a write, so no retrigger
    a_no_start_during_dma: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_dma_active |-> !o_dma_start
    );

endmodule

//--- verilog/work_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2 KB work RAM
// Synchronous write, asynchronous read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "nes_bus_params.svh"

module work_ram (
    input  logic                          i_clk,
    input  logic                          i_we,
    input  logic [`NES_RAM_ADDR_BITS-1:0] i_index,
    input  logic [7:0]                    i_wdata,
    output logic [7:0]                    o_rdata
);

    localparam int RAM_DEPTH = 1 << `NES_RAM_ADDR_BITS;

    logic [7:0] r_mem [RAM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            r_mem[i_index] <= i_wdata;
        end
    end

    // Index arrives already folded into the mirror window
    assign o_rdata = r_mem[i_index];

endmodule

//--- verilog/oam_memory.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite attribute memory
// OAMADDR register and auto-incrementing data port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "nes_bus_params.svh"

module oam_memory (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_addr_we,
    input  logic       i_data_we,
    input  logic       i_data_re,
    input  logic [7:0] i_wdata,
    output logic [7:0] o_rdata
);

    logic [7:0] r_oam [`NES_OAM_SIZE];
    logic [7:0] r_oam_addr;

    // 8-bit address wraps at 256 by itself
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            r_oam_addr <= 8'h00;
        end else if (i_addr_we) begin
            r_oam_addr <= i_wdata;
        end else if (i_data_we || i_data_re) begin
            r_oam_addr <= r_oam_addr + 8'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_data_we) begin
            r_oam[r_oam_addr] <= i_wdata;
        end
    end

    // Read returns the byte before the address steps
    assign o_rdata = r_oam[r_oam_addr];

    a_data_we_re_excl: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        !(i_data_we && i_data_re)
    );

endmodule

//--- verilog/cpu_bus_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2A03 bus side
// DMA engine, bus controller, work RAM and OAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "nes_bus_params.svh"

module cpu_bus_top import nes_bus_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_clk_en,
    input  bus_req_t   i_cpu_req,
    output logic [7:0] o_cpu_rdata,
    output logic       o_cpu_clk_en,
    output logic       o_dma_active
);

    bus_req_t                      w_dma_req;
    logic                          w_dma_start;
    logic [7:0]                    w_dma_page;
    logic                          w_ram_we;
    logic [`NES_RAM_ADDR_BITS-1:0] w_ram_index;
    logic [7:0]                    w_ram_rdata;
    logic                          w_oam_addr_we;
    logic                          w_oam_data_we;
    logic                          w_oam_data_re;
    logic [7:0]                    w_oam_rdata;
    logic [7:0]                    w_wdata;

    oam_dma u_oam_dma (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clk_en  (i_clk_en),
        .i_start   (w_dma_start),
        .i_page    (w_dma_page),
        .i_rdata   (o_cpu_rdata),
        .o_req     (w_dma_req),
        .o_active  (o_dma_active)
    );

    bus_controller u_bus_controller (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_clk_en      (i_clk_en),
        .i_cpu_req     (i_cpu_req),
        .i_dma_req     (w_dma_req),
        .i_dma_active  (o_dma_active),
        .i_ram_rdata   (w_ram_rdata),
        .i_oam_rdata   (w_oam_rdata),
        .o_ram_we      (w_ram_we),
        .o_ram_index   (w_ram_index),
        .o_oam_addr_we (w_oam_addr_we),
        .o_oam_data_we (w_oam_data_we),
        .o_oam_data_re (w_oam_data_re),
        .o_wdata       (w_wdata),
        .o_dma_start   (w_dma_start),
        .o_dma_page    (w_dma_page),
        .o_cpu_rdata   (o_cpu_rdata),
        .o_cpu_clk_en  (o_cpu_clk_en)
    );

    work_ram u_work_ram (
        .i_clk   (i_clk),
        .i_we    (w_ram_we),
        .i_index (w_ram_index),
        .i_wdata (w_wdata),
        .o_rdata (w_ram_rdata)
    );

    oam_memory u_oam_memory (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_addr_we (w_oam_addr_we),
        .i_data_we (w_oam_data_we),
        .i_data_re (w_oam_data_re),
        .i_wdata   (w_wdata),
        .o_rdata   (w_oam_rdata)
    );

endmodule

//--- testbench/tb_cpu_bus_tasks.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus cycles, compare tasks and directed tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_CPU_BUS_TASKS_SVH
`define TB_CPU_BUS_TASKS_SVH

function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
endfunction

task automatic compare_byte(input logic [7:0] expected, input logic [7:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch in %s: expected %02h, actual %02h", test_name, expected, actual);
    end
endtask

task automatic compare_bit(input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch in %s: expected %b, actual %b", test_name, expected, actual);
    end
endtask

task automatic compare_count(input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
        error_count++;
        $display("Mismatch in %s: expected %0d, actual %0d", test_name, expected, actual);
    end
endtask

task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
endtask

task automatic end_test();
    if (error_count != errors_at_start) begin
        failed_tests++;
    end
    $display("%s finished with %0d errors", test_name, error_count - errors_at_start);
endtask

// Called on a rising edge; holds the request until the CPU is enabled
task automatic bus_cycle(input bus_req_t req, output logic [7:0] rdata);
    logic accepted;
    accepted = 1'b0;
    cpu_req <= req;
    while (!accepted) begin
        @(negedge clk);
        accepted = cpu_clk_en;
        rdata    = cpu_rdata;
        @(posedge clk);
    end
endtask

task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    bus_cycle('{addr: addr, wdata: data, rw: 1'b0}, unused);
endtask

task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
    bus_cycle('{addr: addr, wdata: 8'h00, rw: 1'b1}, data);
endtask

// Counts enabled cycles with the CPU frozen after a $4014 write
task automatic measure_dma(input logic random_gate);
    logic [31:0] r;
    int          low_cycles;
    int          active_cycles;
    logic        done;
    low_cycles    = 0;
    active_cycles = 0;
    done          = 1'b0;
    cpu_req <= '{addr: 16'h0000, wdata: 8'h00, rw: 1'b1};
    while (!done) begin
        if (random_gate) begin
            r = $random(seed);
            clk_en <= r[0];
        end
        @(negedge clk);
        if (clk_en && cpu_clk_en) begin
            done = 1'b1;
        end else if (clk_en) begin
            low_cycles++;
            if (dma_active) begin
                active_cycles++;
            end
        end
        @(posedge clk);
    end
    clk_en <= 1'b1;
    compare_count(513, low_cycles);
    compare_count(513, active_cycles);
endtask

task automatic check_oam();
    logic [7:0] d;
    cpu_write(`NES_ADDR_OAMADDR, 8'h00);
    for (int i = 0; i < `NES_OAM_SIZE; i++) begin
        cpu_read(`NES_ADDR_OAMDATA, d);
        compare_byte(oam_model[8'(i)], d);
    end
endtask

task automatic run_dma(input logic [7:0] page, input logic [7:0] offset,
                       input logic random_gate);
    logic [7:0] d;
    int         base;
    base = int'(page) * 256;
    for (int n = 0; n < 256; n++) begin
        d = random_byte();
        ram_model[11'(base + n)] = d;
        cpu_write(16'(base + n), d);
    end
    cpu_write(`NES_ADDR_OAMADDR, offset);
    cpu_write(`NES_ADDR_OAMDMA, page);
    measure_dma(random_gate);
    // OAM fills from OAMADDR and wraps
    for (int n = 0; n < 256; n++) begin
        oam_model[8'(int'(offset) + n)] = ram_model[11'(base + n)];
    end
    check_oam();
endtask

task automatic test_ram_mirror();
    logic [7:0] d;
    start_test("ram_mirror");
    for (int a = 0; a < 2048; a++) begin
        d = random_byte();
        ram_model[11'(a)] = d;
        cpu_write(16'(a), d);
    end
    for (int m = 1; m < 4; m++) begin
        for (int a = 0; a < 2048; a++) begin
            cpu_read(16'(a + m * 2048), d);
            compare_byte(ram_model[11'(a)], d);
        end
    end
    end_test();
endtask

task automatic test_oam_port();
    logic [7:0] start;
    logic [7:0] d;
    start_test("oam_port");
    start = random_byte();
    cpu_write(`NES_ADDR_OAMADDR, start);
    for (int i = 0; i < `NES_OAM_SIZE; i++) begin
        d = random_byte();
        oam_model[8'(int'(start) + i)] = d;
        cpu_write(`NES_ADDR_OAMDATA, d);
    end
    // Readback starts half the memory away from where the fill began
    cpu_write(`NES_ADDR_OAMADDR, start ^ 8'h80);
    for (int i = 0; i < `NES_OAM_SIZE; i++) begin
        cpu_read(`NES_ADDR_OAMDATA, d);
        compare_byte(oam_model[8'(int'(start ^ 8'h80) + i)], d);
    end
    end_test();
endtask

task automatic test_dma_copy();
    start_test("dma_copy");
    run_dma(8'h02, 8'h00, 1'b0);
    end_test();
endtask

task automatic test_dma_offset();
    start_test("dma_offset");
    run_dma(8'h03, random_byte(), 1'b0);
    end_test();
endtask

task automatic test_clk_en_gating();
    start_test("clk_en_gating");
    run_dma(8'h05, random_byte(), 1'b1);
    end_test();
endtask

task automatic test_open_bus();
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] d;
    start_test("open_bus");
    x = random_byte();
    y = x ^ 8'h5a;
    cpu_write(16'h0020, x);
    cpu_write(16'h0021, y);
    // Previous cycle a write
    cpu_read(16'h5000, d);
    compare_byte(y, d);
    // Previous cycle a RAM read
    cpu_read(16'h0020, d);
    compare_byte(x, d);
    cpu_read(16'h5000, d);
    compare_byte(x, d);
    end_test();
endtask

`endif

//--- testbench/tb_cpu_bus_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the 2A03 bus side
// Acts as the CPU and checks RAM, OAM and DMA
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "nes_bus_params.svh"

module tb_cpu_bus_top import nes_bus_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int N_TESTS     = 6;
    // Longest test is the full RAM mirror sweep, about 8200 cycles
    localparam int TEST_CYCLES = 9000;
    localparam int WATCHDOG_NS = (N_TESTS * TEST_CYCLES + 100) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       clk_en;
    bus_req_t   cpu_req;
    logic [7:0] cpu_rdata;
    logic       cpu_clk_en;
    logic       dma_active;

    // Reference contents of the two memories
    logic [7:0] ram_model [2048];
    logic [7:0] oam_model [`NES_OAM_SIZE];

    integer     seed = 32'h56fa;
    int         error_count = 0;
    int         check_count = 0;
    int         failed_tests = 0;
    int         errors_at_start = 0;
    string      test_name = "none";

    cpu_bus_top i_cpu_bus_top (
        .i_clk        (clk),
        .i_reset_n    (reset_n),
        .i_clk_en     (clk_en),
        .i_cpu_req    (cpu_req),
        .o_cpu_rdata  (cpu_rdata),
        .o_cpu_clk_en (cpu_clk_en),
        .o_dma_active (dma_active)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "tb_cpu_bus_tasks.svh"

    initial begin
        logic [7:0] rdata;
        reset_n <= 1'b0;
        clk_en  <= 1'b1;
        cpu_req <= '{addr: 16'h0000, wdata: 8'h00, rw: 1'b1};
        repeat (4) @(posedge clk);
        @(negedge clk);
        test_name = "reset";
        compare_bit(1'b0, dma_active);
        compare_bit(1'b0, cpu_clk_en);
        @(posedge clk);
        reset_n <= 1'b1;
        // Open-bus latch starts cleared
        cpu_read(16'h5000, rdata);
        compare_byte(8'h00, rdata);

        test_ram_mirror();
        test_oam_port();
        test_dma_copy();
        test_dma_offset();
        test_clk_en_gating();
        test_open_bus();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 N_TESTS, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        dma_state_e state;
        #(WATCHDOG_NS);
        state = i_cpu_bus_top.u_oam_dma.r_state;
        $display("Watchdog expired during test %s with the DMA in state %s",
                 test_name, state.name());
        $display("Errors found");
        $finish;
    end

endmodule

//--- list.f
+incdir+verilog
+incdir+testbench
verilog/nes_bus_pkg.sv
verilog/oam_dma.sv
verilog/bus_controller.sv
verilog/work_ram.sv
verilog/oam_memory.sv
verilog/cpu_bus_top.sv
testbench/tb_cpu_bus_top.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := -sv --timing --assert --timescale 1ns/100ps
TOP       := tb_cpu_bus_top
FILELIST  := list.f
BUILD_DIR := obj_dir
PASS_MSG  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Exit status comes from grep, so a missing pass line fails the target
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
